/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_videoTiming
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= Test completed successfully

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* apbRegCtrl.sv */
`include "vid_macros.svh"

module apbRegCtrl (
    input  logic                   clk,
    input  logic                   rstN,
    input  vidPkg::apbReq_t        req,
    output vidPkg::apbRsp_t        rsp,
    input  logic [`VID_VCNT_W-1:0] vCount,
    input  logic                   vBlank,
    output vidPkg::vidCtrl_t       ctrl,
    output vidPkg::promWr_t        promWr
);
    import vidPkg::*;

    typedef enum logic [1:0] {sIdle, sAccess, sPromWait} apbState_t;

    apbState_t state;
    regWord_u  wrWord;     // pwdata seen as ctrl or PROM entry
    ctrlWord_t rdCtrl;
    logic      hitCtrl;
    logic      hitProm;
    logic      hitStat;
    logic      unmapped;
    logic      promWrite;

    assign wrWord    = req.pwdata;
    assign hitCtrl   = req.paddr == `VID_ADDR_CTRL;
    assign hitProm   = req.paddr == `VID_ADDR_PROM;
    assign hitStat   = req.paddr == `VID_ADDR_STAT;
    assign unmapped  = !(hitCtrl || hitProm || hitStat);
    assign promWrite = req.pwrite && hitProm;    // Needs one wait state

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state <= sIdle;
            ctrl  <= '0;                         // Enable and flip off
        end else begin
            case (state)
                sIdle: begin
                    if (req.psel && !req.penable)
                        state <= sAccess;        // Setup phase seen
                end
                sAccess: begin
                    if (promWrite) begin
                        state <= sPromWait;
                    end else begin
                        state <= sIdle;
                        // Control write lands on the completing edge
                        if (req.pwrite && hitCtrl) begin
                            ctrl.flip   <= wrWord.ctrl.flip;
                            ctrl.enable <= wrWord.ctrl.enable;
                        end
                    end
                end
                sPromWait: state <= sIdle;       // Second access cycle ends it
                default:   state <= sIdle;
            endcase
        end
    end

    // Readback view of the control register
    always_comb begin
        rdCtrl        = '0;
        rdCtrl.flip   = ctrl.flip;
        rdCtrl.enable = ctrl.enable;
    end

    always_comb begin
        rsp = '0;
        case (state)
            sAccess: begin
                rsp.pready  = !promWrite;
                rsp.pslverr = unmapped;          // No side effects on a miss
                if (!req.pwrite) begin
                    if (hitCtrl)
                        rsp.prdata = rdCtrl;
                    else if (hitStat)
                        rsp.prdata = `VID_DATA_W'({vBlank, vCount});  // Unflipped count
                end
            end
            sPromWait: rsp.pready = 1'b1;
            default: rsp = '0;
        endcase
    end

    // PROM write strobe in the first access cycle only
    assign promWr.we   = (state == sAccess) && promWrite;
    assign promWr.addr = wrWord.prom.addr;
    assign promWr.data = wrWord.prom.data;

endmodule

/* build.f */
+incdir+.
vidPkg.sv
apbRegCtrl.sv
pixelStrobeGen.sv
hPosCounter.sv
vPosCounter.sv
lineStepProm.sv
videoTiming.sv
tb_videoTiming.sv

/* hPosCounter.sv */
`include "vid_macros.svh"

module hPosCounter (
    input  logic                    clk,
    input  logic                    rstN,
    input  logic                    pxl2Cen,
    input  vidPkg::vidCtrl_t        ctrl,
    output logic [`VID_POS_W-1:0]   hPos,
    output logic                    hBlank,
    output logic                    hBlankDma,
    output logic                    h2o,
    output logic [`VID_PROM_AW-1:0] promAddr
);
    logic [`VID_HCNT_W-1:0]  hCnt;
    logic [`VID_HCNT_W-1:0]  hNext;
    logic [`VID_DMA_LAG-1:0] dmaDly;    // hBlank history, one tap per step

    // Wrap at end of line
    assign hNext = (hCnt == `VID_HCNT_W'(`VID_H_TOTAL - 1)) ? '0 : hCnt + 1'b1;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            hCnt   <= '0;
            hBlank <= 1'b0;
            dmaDly <= '0;
        end else if (pxl2Cen) begin
            hCnt   <= hNext;
            hBlank <= hNext >= `VID_HCNT_W'(`VID_H_ACTIVE);   // From the new count
            // Old hBlank shifts in as the new one is registered
            dmaDly <= {dmaDly[`VID_DMA_LAG-2:0], hBlank};
        end
    end

    assign hBlankDma = dmaDly[`VID_DMA_LAG-1];

    // Screen flip touches the coarse bits only
    assign hPos = {hCnt[7:3] ^ {5{ctrl.flip}}, hCnt[2:0]};
    assign h2o  = hCnt[2] ^ ctrl.flip;

    // Line-step PROM address
    assign promAddr = {hBlank, hCnt[7:1]};

endmodule

/* lineStepProm.sv */
`include "vid_macros.svh"

module lineStepProm (
    input  logic                    clk,
    input  vidPkg::promWr_t         promWr,
    input  logic [`VID_PROM_AW-1:0] rdAddr,
    output logic [`VID_PROM_DW-1:0] rdData
);
    logic [`VID_PROM_DW-1:0] mem [`VID_PROM_DEPTH];   // Loaded by the host

    // Host write port
    always_ff @(posedge clk) begin
        if (promWr.we)
            mem[promWr.addr] <= promWr.data;
    end

    // Registered read, one clock of latency
    always_ff @(posedge clk) begin
        rdData <= mem[rdAddr];
    end

endmodule

/* pixelStrobeGen.sv */
`include "vid_macros.svh"

module pixelStrobeGen (
    input  logic             clk,
    input  logic             rstN,
    input  vidPkg::vidCtrl_t ctrl,
    output logic             pxl2Cen,
    output logic             pxlCen
);
    logic [`VID_DIV_W-1:0] divCnt;
    logic                  divEnd;
    logic                  half;     // Picks every second pxl2Cen

    assign divEnd = divCnt == `VID_DIV_W'(`VID_PXL_DIV - 1);

    always_ff @(posedge clk) begin
        if (!rstN || !ctrl.enable) begin
            divCnt  <= '0;            // Held clear while disabled
            half    <= 1'b0;
            pxl2Cen <= 1'b0;
            pxlCen  <= 1'b0;
        end else begin
            divCnt  <= divEnd ? '0 : divCnt + 1'b1;
            pxl2Cen <= divEnd;        // One clock wide
            pxlCen  <= divEnd && half;
            if (divEnd)
                half <= !half;
        end
    end

endmodule

/* tb_videoTiming.sv */
`include "vid_macros.svh"

module tb_videoTiming;
    timeunit 1ns;
    timeprecision 1ps;
    import vidPkg::*;

    localparam int LAG     = `VID_DMA_LAG;
    localparam int FILLCYC = `VID_PROM_DEPTH * 4;                   // Setup, access, wait, idle
    localparam int RUNCYC  = 3 * `VID_H_TOTAL * 256 * `VID_PXL_DIV; // Three frames of steps
    localparam int LIMIT   = 2 * (FILLCYC + RUNCYC);

    logic     clk;
    logic     rstN;
    apbReq_t  apbReq;
    apbRsp_t  apbRsp;
    beamPos_t beam;
    logic     pxlCen;

    // Reference model
    logic [1:0]     mState;    // 0 idle, 1 access, 2 PROM wait
    logic           mFlip;
    logic           mEn;
    int             mDiv;
    logic           mHalf;
    logic           mPxl2;
    logic           mPxl;
    logic [8:0]     mH;
    logic [8:0]     mHNext;
    logic           mHBlank;
    logic [LAG-1:0] mDma;      // Delay line behind hBlank
    logic [3:0]     mMem [256];
    logic [3:0]     mRd;
    logic           mStepPrev;
    logic [8:0]     mV;
    logic [8:0]     mVNext;
    logic           mVBlank;
    logic           mPromWr;
    int             vbSets   = 0;
    int             vbClears = 0;
    int             cycles   = 0;
    logic [31:0]    lcgState;
    logic           flipReq;

    videoTiming u_dut (
        .clk(clk), .rstN(rstN), .apbReq(apbReq), .apbRsp(apbRsp),
        .beam(beam), .pxlCen(pxlCen)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    assign mHNext  = (mH == 9'(`VID_H_TOTAL - 1)) ? 9'd0 : mH + 9'd1;
    assign mVNext  = mV + 9'd1;                                        // Wraps at 512
    assign mPromWr = apbReq.pwrite && (apbReq.paddr == `VID_ADDR_PROM);

    always @(posedge clk) begin
        mRd <= mMem[{mHBlank, mH[7:1]}];     // PROM read, one clock late
        if (!rstN) begin
            mState    <= 2'd0;
            mFlip     <= 1'b0;
            mEn       <= 1'b0;
            mH        <= '0;
            mHBlank   <= 1'b0;
            mDma      <= '0;
            mStepPrev <= 1'b0;
            mV        <= '0;
            mVBlank   <= 1'b0;
        end else begin
            case (mState)
                2'd0: if (apbReq.psel && !apbReq.penable) mState <= 2'd1;
                2'd1: begin
                    mState <= mPromWr ? 2'd2 : 2'd0;
                    if (mPromWr)
                        mMem[apbReq.pwdata[7:0]] <= apbReq.pwdata[11:8];
                    else if (apbReq.pwrite && (apbReq.paddr == `VID_ADDR_CTRL)) begin
                        mFlip <= apbReq.pwdata[0];
                        mEn   <= apbReq.pwdata[1];
                    end
                end
                default: mState <= 2'd0;
            endcase
            if (mPxl2) begin
                mH        <= mHNext;
                mHBlank   <= mHNext >= 9'(`VID_H_ACTIVE);
                mDma      <= {mDma[LAG-2:0], mHBlank};
                mStepPrev <= mRd[1];          // Line-step bit
                if (mRd[1] && !mStepPrev) begin
                    mV <= mVNext;
                    if (mVNext == 9'(`VID_VB_START)) begin
                        mVBlank <= 1'b1;
                        vbSets  <= vbSets + 1;
                    end else if (mVNext == 9'(`VID_VB_END)) begin
                        mVBlank  <= 1'b0;
                        vbClears <= vbClears + 1;
                    end
                end
            end
        end
        if (!rstN || !mEn) begin             // Strobes held while disabled
            mDiv  <= 0;
            mHalf <= 1'b0;
            mPxl2 <= 1'b0;
            mPxl  <= 1'b0;
        end else begin
            mDiv  <= (mDiv == `VID_PXL_DIV - 1) ? 0 : mDiv + 1;
            mPxl2 <= (mDiv == `VID_PXL_DIV - 1);
            mPxl  <= (mDiv == `VID_PXL_DIV - 1) && mHalf;
            if (mDiv == `VID_PXL_DIV - 1)
                mHalf <= !mHalf;
        end
    end

    // Run length guard
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= LIMIT) begin
            $display("Timeout: run still going after %0d cycles", LIMIT);
            abortRun();
        end
    end

    function automatic logic [31:0] nextRand();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    function automatic beamPos_t expectBeam();
        beamPos_t b;
        b.h         = {mH[7:3] ^ {5{mFlip}}, mH[2:0]};  // Coarse bits flip
        b.v         = mV[8:1] ^ {8{mFlip}};
        b.hBlank    = mHBlank;
        b.hBlankDma = mDma[LAG-1];
        b.vBlank    = mVBlank;
        b.h2o       = mH[2] ^ mFlip;
        return b;
    endfunction

    function automatic apbRsp_t expectRsp();
        apbRsp_t r;
        r = '0;
        if (mState == 2'd1) begin
            r.pready  = !mPromWr;
            r.pslverr = !(apbReq.paddr inside {`VID_ADDR_CTRL, `VID_ADDR_PROM, `VID_ADDR_STAT});
            if (!apbReq.pwrite && (apbReq.paddr == `VID_ADDR_CTRL))
                r.prdata = {30'd0, mEn, mFlip};
            else if (!apbReq.pwrite && (apbReq.paddr == `VID_ADDR_STAT))
                r.prdata = {22'd0, mVBlank, mV};               // Unflipped count
        end else if (mState == 2'd2) begin
            r.pready = 1'b1;
        end
        return r;
    endfunction

    task automatic abortRun();
        $display("Test failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic checkBeam(input beamPos_t exp);
        if (beam !== exp) begin
            $display("[ERROR] beam expected %h actual %h", exp, beam);
            abortRun();
        end
    endtask

    task automatic checkRsp(input apbRsp_t exp, input apbRsp_t act);
        if (act !== exp) begin
            $display("[ERROR] apbRsp expected %h actual %h", exp, act);
            abortRun();
        end
    endtask

    task automatic checkPxl(input logic exp);
        if (pxlCen !== exp) begin
            $display("[ERROR] pxlCen expected %h actual %h", exp, pxlCen);
            abortRun();
        end
    endtask

    // Falling edge, outputs settled
    task automatic tick();
        @(negedge clk);
        checkBeam(expectBeam());
        checkRsp(expectRsp(), apbRsp);
        checkPxl(mPxl);
    endtask

    task automatic apbXfer(input logic [3:0] addr, input logic wr, input logic [31:0] data,
                           output apbRsp_t got, output int waits);
        apbReq.paddr   = addr;
        apbReq.psel    = 1'b1;
        apbReq.penable = 1'b0;
        apbReq.pwrite  = wr;
        apbReq.pwdata  = data;
        waits          = 0;
        tick();
        apbReq.penable = 1'b1;
        #1;
        while (!apbRsp.pready) begin         // Hold request through wait states
            waits++;
            tick();
            #1;
        end
        got = apbRsp;
        tick();
        apbReq = '0;
    endtask

    // Control write with readback
    task automatic writeCtrl(input logic flip, input logic [29:0] rsvd);
        apbRsp_t got;
        apbRsp_t want;
        int      waits;
        apbXfer(`VID_ADDR_CTRL, 1'b1, {rsvd, 1'b1, flip}, got, waits);
        apbXfer(`VID_ADDR_CTRL, 1'b0, 32'd0, got, waits);
        want        = '0;
        want.prdata = {30'd0, 1'b1, flip};
        want.pready = 1'b1;
        checkRsp(want, got);
    endtask

    initial begin
        apbRsp_t     got;
        int          waits;
        int          start;
        logic [31:0] r;
        logic [3:0]  addr;
        lcgState = 32'h464e25fe;
        flipReq  = 1'b0;
        apbReq   = '0;
        rstN     = 1'b0;
        repeat (5) tick();
        rstN = 1'b1;
        for (int i = 0; i < `VID_PROM_DEPTH; i++) begin
            r = nextRand();
            apbXfer(`VID_ADDR_PROM, 1'b1, {20'd0, r[31:28], 8'(i)}, got, waits);
            if (waits != 1) begin
                $display("[ERROR] PROM write waits expected %h actual %h", 1, waits);
                abortRun();
            end
        end
        writeCtrl(1'b0, 30'd0);              // Strobes start here
        start = cycles;
        while (cycles - start < RUNCYC) begin
            r = nextRand();
            if (r[31:27] != 5'd0) begin
                tick();
            end else begin
                case (r[26:24])
                    3'd0, 3'd1: begin
                        flipReq = !flipReq;
                        writeCtrl(flipReq, r[29:0]);
                    end
                    3'd2, 3'd3: apbXfer(`VID_ADDR_STAT, 1'b0, 32'd0, got, waits);
                    3'd4: begin
                        addr = r[23:20];
                        if (addr inside {`VID_ADDR_CTRL, `VID_ADDR_PROM, `VID_ADDR_STAT})
                            addr = 4'hc;             // Force a miss
                        apbXfer(addr, r[19], r, got, waits);
                    end
                    3'd5: apbXfer(`VID_ADDR_PROM, 1'b0, 32'd0, got, waits);
                    3'd6: apbXfer(`VID_ADDR_PROM, 1'b1, {20'd0, r[11:0]}, got, waits);
                    default: tick();
                endcase
            end
        end
        if (vbSets < 3 || vbClears < 3) begin
            $display("vBlank did not set and clear over three frames");
            abortRun();
        end else begin
            $display("Test completed successfully");
            $finish;
        end
    end

endmodule

/* vPosCounter.sv */
`include "vid_macros.svh"

module vPosCounter (
    input  logic                    clk,
    input  logic                    rstN,
    input  logic                    pxl2Cen,
    input  vidPkg::vidCtrl_t        ctrl,
    input  logic [`VID_PROM_DW-1:0] promData,
    output logic [`VID_POS_W-1:0]   vPos,
    output logic [`VID_VCNT_W-1:0]  vCount,
    output logic                    vBlank
);
    logic                   stepBit;
    logic                   stepPrev;    // Line-step bit at last pxl2Cen
    logic                   stepRise;
    logic [`VID_VCNT_W-1:0] vNext;

    assign stepBit  = promData[`VID_STEP_BIT];
    assign stepRise = stepBit && !stepPrev;
    assign vNext    = vCount + 1'b1;     // Wraps at 512

    always_ff @(posedge clk) begin
        if (!rstN) begin
            stepPrev <= 1'b0;
            vCount   <= '0;
            vBlank   <= 1'b0;
        end else if (pxl2Cen) begin
            stepPrev <= stepBit;
            if (stepRise) begin
                vCount <= vNext;
                // Blank window from the new count
                if (vNext == `VID_VCNT_W'(`VID_VB_START))
                    vBlank <= 1'b1;
                else if (vNext == `VID_VCNT_W'(`VID_VB_END))
                    vBlank <= 1'b0;
            end
        end
    end

    // Two count steps per visible row
    assign vPos = vCount[8:1] ^ {`VID_POS_W{ctrl.flip}};

endmodule

/* vidPkg.sv */
`include "vid_macros.svh"

package vidPkg;

    // APB request from the host
    typedef struct packed {
        logic [`VID_ADDR_W-1:0] paddr;
        logic                   psel;
        logic                   penable;
        logic                   pwrite;
        logic [`VID_DATA_W-1:0] pwdata;
    } apbReq_t;

    typedef struct packed {
        logic [`VID_DATA_W-1:0] prdata;
        logic                   pready;
        logic                   pslverr;
    } apbRsp_t;

    // Control register layout, flip in bit 0
    typedef struct packed {
        logic [29:0] rsvd;
        logic        enable;
        logic        flip;
    } ctrlWord_t;

    // PROM entry layout, addr in 7:0, data in 11:8
    typedef struct packed {
        logic [19:0]             rsvd;
        logic [`VID_PROM_DW-1:0] data;
        logic [`VID_PROM_AW-1:0] addr;
    } promEntry_t;

    // One write word, decoded by offset
    typedef union packed {
        ctrlWord_t  ctrl;
        promEntry_t prom;
    } regWord_u;

    typedef struct packed {
        logic                    we;
        logic [`VID_PROM_AW-1:0] addr;
        logic [`VID_PROM_DW-1:0] data;
    } promWr_t;

    typedef struct packed {
        logic flip;
        logic enable;
    } vidCtrl_t;

    // Timing outputs of the top level
    typedef struct packed {
        logic [`VID_POS_W-1:0] h;
        logic [`VID_POS_W-1:0] v;
        logic                  hBlank;
        logic                  hBlankDma;
        logic                  vBlank;
        logic                  h2o;
    } beamPos_t;

endpackage

/* vid_macros.svh */
`ifndef VID_MACROS_SVH
`define VID_MACROS_SVH

// Bus and word widths
`define VID_DATA_W      32
`define VID_ADDR_W      4
`define VID_POS_W       8      // Beam position outputs
`define VID_HCNT_W      9      // Line counter, covers H_TOTAL
`define VID_VCNT_W      9      // Frame counter, wraps at 512
`define VID_PROM_AW     8
`define VID_PROM_DW     4
`define VID_PROM_DEPTH  256
`define VID_STEP_BIT    1      // Line-step bit of the PROM word

// Pixel strobe divider
`define VID_PXL_DIV     2      // Clocks per pxl2Cen
`define VID_DIV_W       4      // Divider counter width

// Line and frame timing, in pxl2Cen steps
`define VID_H_ACTIVE    256
`define VID_H_TOTAL     384
`define VID_DMA_LAG     8
`define VID_VB_START    480    // vBlank sets here
`define VID_VB_END      32     // and clears here

// APB byte offsets
`define VID_ADDR_CTRL   4'h0
`define VID_ADDR_PROM   4'h4
`define VID_ADDR_STAT   4'h8

`endif

/* videoTiming.sv */
`include "vid_macros.svh"

module videoTiming (
    input  logic             clk,
    input  logic             rstN,
    input  vidPkg::apbReq_t  apbReq,
    output vidPkg::apbRsp_t  apbRsp,
    output vidPkg::beamPos_t beam,
    output logic             pxlCen
);
    import vidPkg::*;

    vidCtrl_t                ctrl;
    promWr_t                 promWr;
    logic                    pxl2Cen;
    logic [`VID_POS_W-1:0]   hPos;
    logic                    hBlank;
    logic                    hBlankDma;
    logic                    h2o;
    logic [`VID_PROM_AW-1:0] promAddr;
    logic [`VID_PROM_DW-1:0] promData;
    logic [`VID_POS_W-1:0]   vPos;
    logic [`VID_VCNT_W-1:0]  vCount;   // Unflipped, for status
    logic                    vBlank;

    apbRegCtrl uApb (
        .clk(clk), .rstN(rstN), .req(apbReq), .rsp(apbRsp),
        .vCount(vCount), .vBlank(vBlank), .ctrl(ctrl), .promWr(promWr)
    );

    pixelStrobeGen uStrobe (
        .clk(clk), .rstN(rstN), .ctrl(ctrl), .pxl2Cen(pxl2Cen), .pxlCen(pxlCen)
    );

    hPosCounter uHPos (
        .clk(clk), .rstN(rstN), .pxl2Cen(pxl2Cen), .ctrl(ctrl), .hPos(hPos),
        .hBlank(hBlank), .hBlankDma(hBlankDma), .h2o(h2o), .promAddr(promAddr)
    );

    lineStepProm uProm (
        .clk(clk), .promWr(promWr), .rdAddr(promAddr), .rdData(promData)
    );

    vPosCounter uVPos (
        .clk(clk), .rstN(rstN), .pxl2Cen(pxl2Cen), .ctrl(ctrl), .promData(promData),
        .vPos(vPos), .vCount(vCount), .vBlank(vBlank)
    );

    // Beam bundle out
    assign beam.h         = hPos;
    assign beam.v         = vPos;
    assign beam.hBlank    = hBlank;
    assign beam.hBlankDma = hBlankDma;
    assign beam.vBlank    = vBlank;
    assign beam.h2o       = h2o;

endmodule
